//--- logic/scu_pkg.sv
// Register map fixed at four 4-bit registers and an 8-bit scan word. No DFT or bypass support
`default_nettype none

package scu_pkg;

    //----------------------------------------------------------------------
    // Widths
    //----------------------------------------------------------------------
    localparam int unsigned SCU_DATA_W      = 4;
    localparam int unsigned SCU_ADDR_W      = 2;
    localparam int unsigned SCU_OP_W        = 2;
    localparam int unsigned SCU_DR_W        = SCU_DATA_W + SCU_ADDR_W + SCU_OP_W;
    // Status synchronizer depth
    localparam int unsigned SCU_SYNC_STAGES = 2;

    //----------------------------------------------------------------------
    // Scan operations and register addresses
    //----------------------------------------------------------------------
    typedef enum logic [SCU_OP_W-1:0] {
        SCU_OP_WRITE   = 2'd0,
        SCU_OP_READ    = 2'd1,
        SCU_OP_SETBITS = 2'd2,
        SCU_OP_CLRBITS = 2'd3
    } scu_op_e;

    typedef enum logic [SCU_ADDR_W-1:0] {
        SCU_ADDR_CONTROL = 2'd0,
        SCU_ADDR_MODE    = 2'd1,
        SCU_ADDR_STATUS  = 2'd2,
        SCU_ADDR_STICKY  = 2'd3
    } scu_addr_e;

    //----------------------------------------------------------------------
    // Scan data register
    //----------------------------------------------------------------------
    // Data on top, op in the bits shifted out first
    typedef struct packed {
        logic [SCU_DATA_W-1:0] data;
        scu_addr_e             addr;
        scu_op_e               op;
    } scu_dr_fields_s;

    // Shift path sees bits, update path sees fields
    typedef union packed {
        logic [SCU_DR_W-1:0] bits;
        scu_dr_fields_s      f;
    } scu_dr_u;

    // Update request from the scan port
    typedef struct packed {
        logic                  upd;
        scu_op_e               op;
        scu_addr_e             addr;
        logic [SCU_DATA_W-1:0] data;
    } scu_csr_req_s;

    //----------------------------------------------------------------------
    // Register layouts
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [1:0] rsvd;
        logic       core_reset;
        logic       sys_reset;
    } scu_control_s;

    typedef struct packed {
        logic [1:0] rsvd;
        logic       hdu_rst_bhv;
        logic       dm_rst_bhv;
    } scu_mode_s;

    // Each bit high while that reset is active
    typedef struct packed {
        logic hdu;
        logic dm;
        logic core;
        logic sys;
    } scu_status_s;

endpackage

`default_nettype wire

//--- logic/scan_chain_port.sv
// TAP strobes must already be synchronous to clk and one cycle wide; capture wins over shift
`timescale 1ns/100ps
`default_nettype none

module scan_chain_port (
    input  logic                           clk,
    input  logic                           pwrup_rst_n_sync,
    // TAP strobes
    input  logic                           ch_sel_i,
    input  logic                           ch_id_i,
    input  logic                           capture_i,
    input  logic                           shift_i,
    input  logic                           update_i,
    input  logic                           tdi_i,
    // Result of the current update from the CSR file
    input  logic [scu_pkg::SCU_DATA_W-1:0] upd_data_i,
    output scu_pkg::scu_csr_req_s          csr_req_o,
    output logic                           tdo_o
);

    logic             chain_hit;
    logic             cap_req;
    logic             shft_req;
    logic             upd_req;
    scu_pkg::scu_dr_u shift_q;
    scu_pkg::scu_dr_u shadow_q;

    //----------------------------------------------------------------------
    // Strobe qualification
    //----------------------------------------------------------------------
    // This chain answers to id zero only
    assign chain_hit = ch_sel_i & ~ch_id_i;
    assign cap_req   = chain_hit & capture_i;
    assign shft_req  = chain_hit & shift_i;
    assign upd_req   = chain_hit & update_i;

    //----------------------------------------------------------------------
    // Shift register
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shift_q <= '0;
        end else if (cap_req) begin
            shift_q <= shadow_q;
        end else if (shft_req) begin
            // LSB first out, TDI enters at the top
            shift_q.bits <= {tdi_i, shift_q.bits[scu_pkg::SCU_DR_W-1:1]};
        end
    end

    assign tdo_o = shift_q.bits[0];

    // Update request straight from the shift word fields
    assign csr_req_o.upd  = upd_req;
    assign csr_req_o.op   = shift_q.f.op;
    assign csr_req_o.addr = shift_q.f.addr;
    assign csr_req_o.data = shift_q.f.data;

    //----------------------------------------------------------------------
    // Shadow register
    //----------------------------------------------------------------------
    // Keeps op and addr, data replaced by the update result
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shadow_q <= '0;
        end else if (upd_req) begin
            shadow_q.f.op   <= shift_q.f.op;
            shadow_q.f.addr <= shift_q.f.addr;
            shadow_q.f.data <= upd_data_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/scu_csr_file.sv
// Status input must already be synchronized to clk; STATUS is read-only and STICKY clears only
`timescale 1ns/100ps
`default_nettype none

module scu_csr_file (
    input  logic                           clk,
    input  logic                           pwrup_rst_n_sync,
    input  scu_pkg::scu_csr_req_s          csr_req_i,
    input  scu_pkg::scu_status_s           status_i,
    output logic [scu_pkg::SCU_DATA_W-1:0] upd_data_o,
    output scu_pkg::scu_control_s          control_o,
    output scu_pkg::scu_mode_s             mode_o
);

    logic [scu_pkg::SCU_DATA_W-1:0] rd_data;
    logic                           wr_en;
    logic                           control_we;
    logic                           mode_we;
    logic                           sticky_we;
    scu_pkg::scu_control_s          control_q;
    scu_pkg::scu_mode_s             mode_q;
    scu_pkg::scu_status_s           status_q;
    logic [scu_pkg::SCU_DATA_W-1:0] status_rise;
    logic [scu_pkg::SCU_DATA_W-1:0] sticky_q;

    //----------------------------------------------------------------------
    // Read mux and update result
    //----------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (csr_req_i.addr)
            scu_pkg::SCU_ADDR_CONTROL: rd_data = control_q;
            scu_pkg::SCU_ADDR_MODE:    rd_data = mode_q;
            scu_pkg::SCU_ADDR_STATUS:  rd_data = status_i;
            scu_pkg::SCU_ADDR_STICKY:  rd_data = sticky_q;
            default:                   rd_data = '0;
        endcase
    end

    // Read-modify-write by opcode
    always_comb begin
        upd_data_o = rd_data;
        case (csr_req_i.op)
            scu_pkg::SCU_OP_WRITE:   upd_data_o = csr_req_i.data;
            scu_pkg::SCU_OP_READ:    upd_data_o = rd_data;
            scu_pkg::SCU_OP_SETBITS: upd_data_o = rd_data | csr_req_i.data;
            scu_pkg::SCU_OP_CLRBITS: upd_data_o = rd_data & ~csr_req_i.data;
            default:                 upd_data_o = rd_data;
        endcase
    end

    //----------------------------------------------------------------------
    // Write decode
    //----------------------------------------------------------------------
    assign wr_en      = csr_req_i.upd && (csr_req_i.op != scu_pkg::SCU_OP_READ);
    assign control_we = wr_en && (csr_req_i.addr == scu_pkg::SCU_ADDR_CONTROL);
    assign mode_we    = wr_en && (csr_req_i.addr == scu_pkg::SCU_ADDR_MODE);
    // Sticky bits only clear through CLRBITS
    assign sticky_we  = csr_req_i.upd && (csr_req_i.op == scu_pkg::SCU_OP_CLRBITS)
                     && (csr_req_i.addr == scu_pkg::SCU_ADDR_STICKY);

    // CONTROL and MODE
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            control_q <= '0;
            mode_q    <= '0;
        end else begin
            if (control_we) begin
                control_q <= upd_data_o;
            end
            if (mode_we) begin
                mode_q <= upd_data_o;
            end
        end
    end

    assign control_o = control_q;
    assign mode_o    = mode_q;

    //----------------------------------------------------------------------
    // Sticky status
    //----------------------------------------------------------------------
    // Rising edge of each status bit
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            status_q <= '0;
        end else begin
            status_q <= status_i;
        end
    end

    assign status_rise = status_i & ~status_q;

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sticky_q <= '0;
        end else begin
            for (int i = 0; i < scu_pkg::SCU_DATA_W; i++) begin
                // New reset event beats a clear in the same cycle
                if (status_rise[i]) begin
                    sticky_q[i] <= 1'b1;
                end else if (sticky_we) begin
                    sticky_q[i] <= upd_data_o[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/reset_sequencer.sv
// Request must be synchronous to clk; a short request still runs the full four-state sequence
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic req_i,
    output logic rst_n_o,
    output logic qlfy_o
);

    // Encoding {busy, qlfy, rst_n} so both outputs come straight from flops
    typedef enum logic [2:0] {
        RUN      = 3'b011,
        QLFY_LOW = 3'b001,
        IN_RESET = 3'b000,
        RELEASE  = 3'b101
    } seq_state_e;

    seq_state_e state_q;
    seq_state_e state_d;

    //----------------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN:      if (req_i) state_d = QLFY_LOW;
            // Qualifier already low, reset follows unconditionally
            QLFY_LOW: state_d = IN_RESET;
            IN_RESET: if (!req_i) state_d = RELEASE;
            // Reset released one cycle before qualifier rises
            RELEASE:  state_d = RUN;
            default:  state_d = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign qlfy_o  = state_q[1];
    assign rst_n_o = state_q[0];

endmodule

`default_nettype wire

//--- logic/scu_reset_ctrl.sv
// All external reset requests must be synchronous to clk; status lags the resets by two cycles
`timescale 1ns/100ps
`default_nettype none

module scu_reset_ctrl (
    input  logic                  clk,
    input  logic                  pwrup_rst_n_sync,
    input  scu_pkg::scu_control_s control_i,
    input  scu_pkg::scu_mode_s    mode_i,
    // External requests, active low
    input  logic                  rst_n_i,
    input  logic                  cpu_rst_n_i,
    input  logic                  ndm_rst_n_i,
    input  logic                  hart_rst_n_i,
    // Generated resets
    output logic                  sys_rst_n_o,
    output logic                  core_rst_n_o,
    output logic                  hdu_rst_n_o,
    output logic                  dm_rst_n_o,
    // RDC qualifiers
    output logic                  sys_qlfy_o,
    output logic                  core_qlfy_o,
    output logic                  hdu_qlfy_o,
    output scu_pkg::scu_status_s  status_o
);

    logic                                     sys_req;
    logic                                     core_req;
    logic                                     hdu_req;
    logic                                     dm_req;
    logic                                     dm_rst_n_q;
    // One {hdu, core, sys} slice per synchronizer stage
    logic [scu_pkg::SCU_SYNC_STAGES-1:0][2:0] sts_sync_q;

    //----------------------------------------------------------------------
    // Request combining
    //----------------------------------------------------------------------
    assign sys_req  = control_i.sys_reset | ~ndm_rst_n_i | ~rst_n_i;
    // Core also goes down with the system
    assign core_req = sys_req | ~hart_rst_n_i | control_i.core_reset | ~cpu_rst_n_i;
    // HDU can be kept out of core resets
    assign hdu_req  = core_req & ~mode_i.hdu_rst_bhv;
    assign dm_req   = mode_i.dm_rst_bhv & control_i.sys_reset;

    //----------------------------------------------------------------------
    // Sequenced resets
    //----------------------------------------------------------------------
    reset_sequencer u_sys_seq (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .req_i            (sys_req),
        .rst_n_o          (sys_rst_n_o),
        .qlfy_o           (sys_qlfy_o)
    );

    reset_sequencer u_core_seq (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .req_i            (core_req),
        .rst_n_o          (core_rst_n_o),
        .qlfy_o           (core_qlfy_o)
    );

    reset_sequencer u_hdu_seq (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .req_i            (hdu_req),
        .rst_n_o          (hdu_rst_n_o),
        .qlfy_o           (hdu_qlfy_o)
    );

    // DM reset has no qualifier, plain registered copy
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            dm_rst_n_q <= 1'b1;
        end else begin
            dm_rst_n_q <= ~dm_req;
        end
    end

    assign dm_rst_n_o = dm_rst_n_q;

    //----------------------------------------------------------------------
    // Status synchronizers
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sts_sync_q <= '0;
        end else begin
            sts_sync_q <= {sts_sync_q[scu_pkg::SCU_SYNC_STAGES-2:0],
                           {~hdu_rst_n_o, ~core_rst_n_o, ~sys_rst_n_o}};
        end
    end

    assign status_o.sys  = sts_sync_q[scu_pkg::SCU_SYNC_STAGES-1][0];
    assign status_o.core = sts_sync_q[scu_pkg::SCU_SYNC_STAGES-1][1];
    assign status_o.hdu  = sts_sync_q[scu_pkg::SCU_SYNC_STAGES-1][2];
    // DM flop already in the clk domain
    assign status_o.dm   = ~dm_rst_n_q;

endmodule

`default_nettype wire

//--- logic/scu_top.sv
// Single clock domain; all inputs synchronous to clk, only pwrup_rst_n_sync resets the unit
`timescale 1ns/100ps
`default_nettype none

module scu_top (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    // Synchronized TAP scan chain
    input  logic ch_sel_i,
    input  logic ch_id_i,
    input  logic capture_i,
    input  logic shift_i,
    input  logic update_i,
    input  logic tdi_i,
    output logic tdo_o,
    // External reset requests
    input  logic rst_n_i,
    input  logic cpu_rst_n_i,
    input  logic ndm_rst_n_i,
    input  logic hart_rst_n_i,
    // Generated resets
    output logic sys_rst_n_o,
    output logic core_rst_n_o,
    output logic hdu_rst_n_o,
    output logic dm_rst_n_o,
    // RDC qualifiers
    output logic sys_rdc_qlfy_o,
    output logic core_rdc_qlfy_o,
    output logic hdu2dm_rdc_qlfy_o,
    // Synchronized status
    output logic sys_rst_status_o,
    output logic core_rst_status_o
);

    scu_pkg::scu_csr_req_s          csr_req;
    logic [scu_pkg::SCU_DATA_W-1:0] upd_data;
    scu_pkg::scu_control_s          control;
    scu_pkg::scu_mode_s             mode;
    scu_pkg::scu_status_s           status;

    //----------------------------------------------------------------------
    // Scan port and registers
    //----------------------------------------------------------------------
    scan_chain_port u_scan (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .ch_sel_i         (ch_sel_i),
        .ch_id_i          (ch_id_i),
        .capture_i        (capture_i),
        .shift_i          (shift_i),
        .update_i         (update_i),
        .tdi_i            (tdi_i),
        .upd_data_i       (upd_data),
        .csr_req_o        (csr_req),
        .tdo_o            (tdo_o)
    );

    scu_csr_file u_csr (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .csr_req_i        (csr_req),
        .status_i         (status),
        .upd_data_o       (upd_data),
        .control_o        (control),
        .mode_o           (mode)
    );

    //----------------------------------------------------------------------
    // Reset generation
    //----------------------------------------------------------------------
    scu_reset_ctrl u_rst (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .control_i        (control),
        .mode_i           (mode),
        .rst_n_i          (rst_n_i),
        .cpu_rst_n_i      (cpu_rst_n_i),
        .ndm_rst_n_i      (ndm_rst_n_i),
        .hart_rst_n_i     (hart_rst_n_i),
        .sys_rst_n_o      (sys_rst_n_o),
        .core_rst_n_o     (core_rst_n_o),
        .hdu_rst_n_o      (hdu_rst_n_o),
        .dm_rst_n_o       (dm_rst_n_o),
        .sys_qlfy_o       (sys_rdc_qlfy_o),
        .core_qlfy_o      (core_rdc_qlfy_o),
        .hdu_qlfy_o       (hdu2dm_rdc_qlfy_o),
        .status_o         (status)
    );

    // Only sys and core status leave the unit
    assign sys_rst_status_o  = status.sys;
    assign core_rst_status_o = status.core;

endmodule

`default_nettype wire

//--- verification/scu_properties.sv
// Qualifier ordering checks for the three sequenced resets; quiet while pwrup_rst_n_sync is low
`timescale 1ns/100ps
`default_nettype none

module scu_properties (
    input logic       clk,
    input logic       pwrup_rst_n_sync,
    // External requests {rst_n, cpu_rst_n, ndm_rst_n, hart_rst_n}
    input logic [3:0] req_n_i,
    // Index 0 sys, 1 core, 2 hdu
    input logic [2:0] seq_rst_n_i,
    input logic [2:0] seq_qlfy_i
);

    // Number of failed assertions
    int fail_count = 0;

    //----------------------------------------------------------------------
    // Qualifier against reset, one pair per sequencer
    //----------------------------------------------------------------------
    for (genvar g = 0; g < 3; g++) begin : g_pair
        // Reset falls exactly one cycle after its qualifier fell
        a_rst_fall : assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
            $fell(seq_rst_n_i[g]) |-> !$past(seq_qlfy_i[g]) && $past(seq_qlfy_i[g], 2))
            else begin
                fail_count++;
                $error("reset %0d fell without its qualifier falling one cycle before", g);
            end

        // Qualifier back up only once the reset is already high
        a_qlfy_rise : assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
            $rose(seq_qlfy_i[g]) |-> seq_rst_n_i[g] && $past(seq_rst_n_i[g]))
            else begin
                fail_count++;
                $error("qualifier %0d rose before its reset was released", g);
            end
    end

    // External requests must be driven
    a_req_known : assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        !$isunknown(req_n_i))
        else begin
            fail_count++;
            $error("external reset request is unknown");
        end

endmodule

bind scu_top scu_properties u_props (
    .clk              (clk),
    .pwrup_rst_n_sync (pwrup_rst_n_sync),
    .req_n_i          ({rst_n_i, cpu_rst_n_i, ndm_rst_n_i, hart_rst_n_i}),
    .seq_rst_n_i      ({hdu_rst_n_o, core_rst_n_o, sys_rst_n_o}),
    .seq_qlfy_i       ({hdu2dm_rdc_qlfy_o, core_rdc_qlfy_o, sys_rdc_qlfy_o})
);

`default_nettype wire

//--- verification/tb_scu.sv
// Run from the project root so the stimulus file resolves; random idle gaps sit between scan phases
`timescale 1ns/100ps
`default_nettype none

module tb_scu;

    localparam int CLK_PERIOD  = 8;
    localparam int MAX_LINES   = 128;
    // Watchdog budget per stimulus line
    localparam int LINE_CYCLES = 40;

    // Observed reset pins, same order as the pin check digits
    typedef struct packed {
        logic sys_rst_n;
        logic core_rst_n;
        logic hdu_rst_n;
        logic dm_rst_n;
        logic sys_qlfy;
        logic core_qlfy;
        logic hdu_qlfy;
        logic sys_status;
        logic core_status;
    } pins_s;

    logic        clk;
    logic        pwrup_rst_n_sync;
    logic        ch_sel;
    logic        ch_id;
    logic        capture;
    logic        shift;
    logic        update;
    logic        tdi;
    logic        tdo;
    logic        rst_n;
    logic        cpu_rst_n;
    logic        ndm_rst_n;
    logic        hart_rst_n;
    pins_s       pins;
    // One command per word: cmd, wait, nine single-digit fields
    logic [47:0] stim [MAX_LINES];
    int          n_lines = 0;
    int          cur_line;
    int          checks = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          assert_fails = 0;
    logic [31:0] lcg_state = 32'h50e82e8f;

    scu_top UUT (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .ch_sel_i          (ch_sel),
        .ch_id_i           (ch_id),
        .capture_i         (capture),
        .shift_i           (shift),
        .update_i          (update),
        .tdi_i             (tdi),
        .tdo_o             (tdo),
        .rst_n_i           (rst_n),
        .cpu_rst_n_i       (cpu_rst_n),
        .ndm_rst_n_i       (ndm_rst_n),
        .hart_rst_n_i      (hart_rst_n),
        .sys_rst_n_o       (pins.sys_rst_n),
        .core_rst_n_o      (pins.core_rst_n),
        .hdu_rst_n_o       (pins.hdu_rst_n),
        .dm_rst_n_o        (pins.dm_rst_n),
        .sys_rdc_qlfy_o    (pins.sys_qlfy),
        .core_rdc_qlfy_o   (pins.core_qlfy),
        .hdu2dm_rdc_qlfy_o (pins.hdu_qlfy),
        .sys_rst_status_o  (pins.sys_status),
        .core_rst_status_o (pins.core_status)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    // LCG step, top two bits give an idle gap of 0 to 3 cycles
    function automatic logic [1:0] next_gap();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:30];
    endfunction

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0d ns: line %0d %s, got %0h expected %0h",
                     $time, cur_line, msg, got, exp);
        end
    endtask

    // All strobes change together on the falling edge
    task automatic drive_tap(input logic cap, input logic sh, input logic upd,
                             input logic bit_in);
        @(negedge clk);
        capture = cap;
        shift   = sh;
        update  = upd;
        tdi     = bit_in;
    endtask

    task automatic idle_gap();
        repeat (next_gap()) drive_tap(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // Shift in, update, capture, shift out; data field returns the update result
    task automatic scan_op(input logic [1:0] op, input logic [1:0] addr,
                           input logic [3:0] data, input logic [3:0] exp);
        logic [7:0] word;
        logic [7:0] rd;
        int         i;
        word = {data, addr, op};
        for (i = 0; i < 8; i++) begin
            drive_tap(1'b0, 1'b1, 1'b0, word[i]);
        end
        idle_gap();
        drive_tap(1'b0, 1'b0, 1'b1, 1'b0);
        idle_gap();
        drive_tap(1'b1, 1'b0, 1'b0, 1'b0);
        idle_gap();
        // tdo holds the next bit from the rising edge on
        for (i = 0; i < 8; i++) begin
            drive_tap(1'b0, 1'b1, 1'b0, 1'b0);
            rd[i] = tdo;
        end
        drive_tap(1'b0, 1'b0, 1'b0, 1'b0);
        check_value(rd[7:4], exp, $sformatf("scan op %0d addr %0d result", op, addr));
        check_value(rd[3:0], {addr, op}, "scan op and addr echo");
    endtask

    task automatic run_command(input logic [47:0] w);
        pins_s exp;
        case (w[47:44])
            4'h1: scan_op(w[33:32], w[29:28], w[27:24], w[23:20]);
            4'h2: begin
                @(negedge clk);
                rst_n      = w[32];
                cpu_rst_n  = w[28];
                ndm_rst_n  = w[24];
                hart_rst_n = w[20];
            end
            4'h3: begin
                exp = {w[32], w[28], w[24], w[20], w[16], w[12], w[8], w[4], w[0]};
                repeat (w[43:36]) @(negedge clk);
                check_value(pins, exp, "reset pins");
            end
            default: begin
                other_errors++;
                $display("unknown command %0h on stimulus line %0d", w[47:44], cur_line);
            end
        endcase
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin
        int n;
        pwrup_rst_n_sync = 1'b0;
        ch_sel           = 1'b0;
        ch_id            = 1'b0;
        capture          = 1'b0;
        shift            = 1'b0;
        update           = 1'b0;
        tdi              = 1'b0;
        rst_n            = 1'b1;
        cpu_rst_n        = 1'b1;
        ndm_rst_n        = 1'b1;
        hart_rst_n       = 1'b1;
        $readmemh("verification/scu_stimulus.txt", stim);
        // Count up to the end marker or the first unloaded word
        n = 0;
        while (n < MAX_LINES && !$isunknown(stim[n]) && stim[n][47:44] != 4'hf) begin
            n++;
        end
        n_lines = n;
        if (n_lines == 0) begin
            other_errors++;
            $display("stimulus file holds no commands");
        end
        repeat (5) @(negedge clk);
        pwrup_rst_n_sync = 1'b1;
        ch_sel           = 1'b1;
        for (cur_line = 0; cur_line < n_lines; cur_line++) begin
            run_command(stim[cur_line]);
        end
        assert_fails = UUT.u_props.fail_count;
        $display("%0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
                 checks, mismatches, other_errors, assert_fails);
        if (mismatches == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (n_lines > 0);
        #(n_lines * LINE_CYCLES * CLK_PERIOD);
        $display("watchdog expired, stimulus did not finish in %0d cycles",
                 n_lines * LINE_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/scu_stimulus.txt
// cmd_wait_f0.._f8 in hex. cmd 1 scan: op addr data expected. cmd 2: rst_n cpu ndm hart levels
// cmd 3 after wait: sys core hdu dm reset, sys core hdu qualifier, sys core status. cmd f ends
// After reset
2_00_1_1_1_1_0_0_0_0_0
3_06_1_1_1_1_1_1_1_0_0
1_00_1_0_0_0_0_0_0_0_0
1_00_1_1_f_0_0_0_0_0_0
1_00_1_2_0_0_0_0_0_0_0
1_00_1_3_0_0_0_0_0_0_0
// MODE write, set bits, clear bits
1_00_0_1_a_a_0_0_0_0_0
1_00_1_1_0_a_0_0_0_0_0
1_00_2_1_5_f_0_0_0_0_0
1_00_1_1_0_f_0_0_0_0_0
1_00_3_1_6_9_0_0_0_0_0
1_00_1_1_0_9_0_0_0_0_0
1_00_0_1_0_0_0_0_0_0_0
3_06_1_1_1_1_1_1_1_0_0
// Debugger system reset, then release
1_00_2_0_1_1_0_0_0_0_0
3_08_0_0_0_1_0_0_0_1_1
1_00_1_2_0_b_0_0_0_0_0
1_00_3_0_1_0_0_0_0_0_0
3_08_1_1_1_1_1_1_1_0_0
1_00_1_2_0_0_0_0_0_0_0
// Sticky holds sys core hdu, write ignored
1_00_1_3_0_b_0_0_0_0_0
1_00_0_3_f_f_0_0_0_0_0
1_00_1_3_0_b_0_0_0_0_0
1_00_3_3_3_8_0_0_0_0_0
1_00_1_3_0_8_0_0_0_0_0
1_00_3_3_8_0_0_0_0_0_0
// Core reset with HDU kept up
1_00_0_1_2_2_0_0_0_0_0
1_00_2_0_2_2_0_0_0_0_0
3_08_1_0_1_1_1_0_1_0_1
1_00_1_2_0_2_0_0_0_0_0
1_00_3_0_2_0_0_0_0_0_0
3_08_1_1_1_1_1_1_1_0_0
1_00_3_3_f_0_0_0_0_0_0
// DM reset follows system reset
1_00_0_1_1_1_0_0_0_0_0
1_00_2_0_1_1_0_0_0_0_0
3_08_0_0_0_0_0_0_0_1_1
1_00_1_2_0_f_0_0_0_0_0
1_00_3_0_1_0_0_0_0_0_0
3_08_1_1_1_1_1_1_1_0_0
1_00_0_1_0_0_0_0_0_0_0
// External requests
2_00_1_1_0_1_0_0_0_0_0
3_08_0_0_0_1_0_0_0_1_1
2_00_1_1_1_1_0_0_0_0_0
3_08_1_1_1_1_1_1_1_0_0
2_00_1_1_1_0_0_0_0_0_0
3_08_1_0_0_1_1_0_0_0_1
2_00_1_1_1_1_0_0_0_0_0
3_08_1_1_1_1_1_1_1_0_0
f_00_0_0_0_0_0_0_0_0_0

//--- tb.f
logic/scu_pkg.sv
logic/scan_chain_port.sv
logic/scu_csr_file.sv
logic/reset_sequencer.sv
logic/scu_reset_ctrl.sv
logic/scu_top.sv
verification/scu_properties.sv
verification/tb_scu.sv

//--- Bender.yml
package:
  name: scu

sources:
  - files:
      - logic/scu_pkg.sv
      - logic/scan_chain_port.sv
      - logic/scu_csr_file.sv
      - logic/reset_sequencer.sv
      - logic/scu_reset_ctrl.sv
      - logic/scu_top.sv
  - target: test
    files:
      - verification/scu_properties.sv
      - verification/tb_scu.sv
